// ==== logic/asluPkg.sv ====
// Shared definitions for the integer execute subsystem
// Widths, opcode encodings, APB register map and the instruction word views
package asluPkg;

   localparam int DataWidth = 32;
   localparam int RegAddrWidth = 5;
   localparam int NumRegs = 32;
   localparam int OpcodeWidth = 6;
   localparam int FuncWidth = 11;
   localparam int ImmWidth = 16;
   localparam int ImmSelBit = 3; // Opcode bit that picks the type B view

   // Instruction queue sizing
   localparam int QueueDepth = 4;
   localparam int QueuePtrWidth = 2;
   localparam int QueueCountWidth = 3;
   localparam logic [QueueCountWidth-1:0] QueueFullCount = QueueCountWidth'(QueueDepth);

   // Arithmetic group, bit 0 sub, bit 1 carry in, bit 2 keep carry
   localparam logic [OpcodeWidth-1:0] OpAdd = 6'h00;
   localparam logic [OpcodeWidth-1:0] OpRsub = 6'h01;
   localparam logic [OpcodeWidth-1:0] OpAddc = 6'h02;
   localparam logic [OpcodeWidth-1:0] OpRsubc = 6'h03;
   localparam logic [OpcodeWidth-1:0] OpAddk = 6'h04;
   localparam logic [OpcodeWidth-1:0] OpCmp = 6'h05;    // rsubk, func bit 0 = cmp, bit 1 = unsigned
   localparam logic [OpcodeWidth-1:0] OpAddkc = 6'h06;
   localparam logic [OpcodeWidth-1:0] OpRsubkc = 6'h07;

   // Logic group
   localparam logic [OpcodeWidth-1:0] OpOr = 6'h20;
   localparam logic [OpcodeWidth-1:0] OpAnd = 6'h21;
   localparam logic [OpcodeWidth-1:0] OpXor = 6'h22;
   localparam logic [OpcodeWidth-1:0] OpAndn = 6'h23;

   // Shift and sign extend, no immediate form
   localparam logic [OpcodeWidth-1:0] OpShift = 6'h24;
   localparam logic [FuncWidth-1:0] FnSra = 11'h001;
   localparam logic [FuncWidth-1:0] FnSrc = 11'h021;
   localparam logic [FuncWidth-1:0] FnSrl = 11'h041;
   localparam logic [FuncWidth-1:0] FnSext8 = 11'h060;
   localparam logic [FuncWidth-1:0] FnSext16 = 11'h061;

   // APB map, register n sits at AddrRegBase + 4n
   localparam int ApbAddrWidth = 8;
   localparam logic [ApbAddrWidth-1:0] AddrInstr = 8'h00;
   localparam logic [ApbAddrWidth-1:0] AddrStatus = 8'h04;
   localparam logic [ApbAddrWidth-1:0] AddrRegBase = 8'h80;

   // One instruction word, register form and immediate form
   typedef union packed {
      struct packed {
         logic [OpcodeWidth-1:0] opcode;
         logic [RegAddrWidth-1:0] rd;
         logic [RegAddrWidth-1:0] ra;
         logic [RegAddrWidth-1:0] rb;
         logic [FuncWidth-1:0] func;
      } typeA;
      struct packed {
         logic [OpcodeWidth-1:0] opcode;
         logic [RegAddrWidth-1:0] rd;
         logic [RegAddrWidth-1:0] ra;
         logic [ImmWidth-1:0] imm;
      } typeB;
   } instrWord_u;

endpackage

// ==== logic/apbCmdPort.sv ====
// APB slave command port
// Pushes instruction words, loads and reads registers, reports status
module apbCmdPort (
   input  logic nclk,
   input  logic nrst,
   input  logic psel_i,
   input  logic penable_i,
   input  logic pwrite_i,
   input  logic [asluPkg::ApbAddrWidth-1:0] paddr_i,
   input  logic [asluPkg::DataWidth-1:0] pwdata_i,
   input  logic [asluPkg::QueueCountWidth-1:0] queueCount_i,
   input  logic busy_i,
   input  logic carry_i,
   input  logic [asluPkg::DataWidth-1:0] hostRdData_i,
   output logic [asluPkg::DataWidth-1:0] prdata_o,
   output logic pready_o,
   output logic pslverr_o,
   output logic pushValid_o,
   output logic [asluPkg::DataWidth-1:0] pushData_o,
   output logic hostWrEn_o,
   output logic [asluPkg::RegAddrWidth-1:0] hostWrAddr_o,
   output logic [asluPkg::DataWidth-1:0] hostWrData_o,
   output logic [asluPkg::RegAddrWidth-1:0] hostRdAddr_o
);

   logic setupSeen;                               // Last cycle was a setup phase
   logic access;
   logic instrSel;
   logic statusSel;
   logic regSel;
   logic [asluPkg::ApbAddrWidth-1:0] regOffset;
   logic queueEmpty;
   logic queueFull;
   logic coreBusy;
   logic instrWrite;
   logic regWrite;

   // Access phase only counts after a proper setup cycle
   always_ff @(posedge nclk) begin
      if (!nrst) begin
         setupSeen <= 1'b0;
      end else begin
         setupSeen <= psel_i & ~penable_i;
      end
   end

   assign access = psel_i & penable_i & setupSeen;

   // Address decode
   assign instrSel = (paddr_i == asluPkg::AddrInstr);
   assign statusSel = (paddr_i == asluPkg::AddrStatus);
   assign regSel = (paddr_i >= asluPkg::AddrRegBase) && (paddr_i[1:0] == 2'b00);
   assign regOffset = paddr_i - asluPkg::AddrRegBase;

   assign queueEmpty = (queueCount_i == '0);
   assign queueFull = (queueCount_i == asluPkg::QueueFullCount);
   assign coreBusy = busy_i | ~queueEmpty;      // Anything queued or in flight

   assign instrWrite = access & pwrite_i & instrSel;
   assign regWrite = access & pwrite_i & regSel;

   // Instruction push, refused when full
   assign pushValid_o = instrWrite & ~queueFull;
   assign pushData_o = pwdata_i;

   // Host register access, writes refused while busy
   assign hostWrEn_o = regWrite & ~coreBusy;
   assign hostWrAddr_o = regOffset[asluPkg::RegAddrWidth+1:2];
   assign hostWrData_o = pwdata_i;
   assign hostRdAddr_o = regOffset[asluPkg::RegAddrWidth+1:2];

   assign pready_o = 1'b1;                      // No wait states
   assign pslverr_o = (instrWrite & queueFull) | (regWrite & coreBusy);

   // Read data, unmapped reads give zero
   always_comb begin
      prdata_o = '0;
      if (statusSel) begin
         // Bit 5 adds busy so the host can wait for the pipeline to drain
         prdata_o = {{(asluPkg::DataWidth-6){1'b0}}, coreBusy, carry_i, queueEmpty, queueCount_i};
      end else if (regSel) begin
         prdata_o = hostRdData_i;
      end
   end

endmodule

// ==== logic/instrQueue.sv ====
// Instruction queue
// Small circular FIFO between the APB port and the execute unit
module instrQueue (
   input  logic nclk,
   input  logic nrst,
   input  logic pushValid_i,
   input  logic [asluPkg::DataWidth-1:0] pushData_i,
   input  logic popReady_i,
   output logic headValid_o,
   output logic [asluPkg::DataWidth-1:0] headData_o,
   output logic [asluPkg::QueueCountWidth-1:0] count_o
);

   logic [asluPkg::DataWidth-1:0] mem [asluPkg::QueueDepth];
   logic [asluPkg::QueuePtrWidth-1:0] wrPtr;
   logic [asluPkg::QueuePtrWidth-1:0] rdPtr;
   logic pop;

   assign headValid_o = (count_o != '0);
   assign headData_o = mem[rdPtr];
   assign pop = popReady_i & headValid_o;       // Pop on empty is dropped

   // Payload storage, full check done by the port
   always_ff @(posedge nclk) begin
      if (pushValid_i) begin
         mem[wrPtr] <= pushData_i;
      end
   end

   always_ff @(posedge nclk) begin
      if (!nrst) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count_o <= '0;
      end else begin
         if (pushValid_i) begin
            wrPtr <= wrPtr + 1'b1;                 // Wraps at depth
         end
         if (pop) begin
            rdPtr <= rdPtr + 1'b1;
         end
         case ({pushValid_i, pop})
            2'b10: count_o <= count_o + 1'b1;
            2'b01: count_o <= count_o - 1'b1;
            default: count_o <= count_o;           // Idle or both at once
         endcase
      end
   end

endmodule

// ==== logic/regFile.sv ====
// General purpose register file
// 32 x 32 bits, r0 reads as zero, one write and three read ports
module regFile (
   input  logic nclk,
   input  logic nrst,
   input  logic wrEn_i,
   input  logic [asluPkg::RegAddrWidth-1:0] wrAddr_i,
   input  logic [asluPkg::DataWidth-1:0] wrData_i,
   input  logic [asluPkg::RegAddrWidth-1:0] rdAddrA_i,
   input  logic [asluPkg::RegAddrWidth-1:0] rdAddrB_i,
   input  logic [asluPkg::RegAddrWidth-1:0] rdAddrHost_i,
   output logic [asluPkg::DataWidth-1:0] rdDataA_o,
   output logic [asluPkg::DataWidth-1:0] rdDataB_o,
   output logic [asluPkg::DataWidth-1:0] rdDataHost_o
);

   logic [asluPkg::DataWidth-1:0] regs [asluPkg::NumRegs];

   // Architectural state starts at zero
   always_ff @(posedge nclk) begin
      if (!nrst) begin
         for (int i = 0; i < asluPkg::NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn_i && (wrAddr_i != '0)) begin
         regs[wrAddr_i] <= wrData_i;               // r0 writes dropped
      end
   end

   // Asynchronous reads
   assign rdDataA_o = (rdAddrA_i == '0) ? '0 : regs[rdAddrA_i];
   assign rdDataB_o = (rdAddrB_i == '0) ? '0 : regs[rdAddrB_i];
   assign rdDataHost_o = (rdAddrHost_i == '0) ? '0 : regs[rdAddrHost_i];

endmodule

// ==== logic/execUnit.sv ====
// Arithmetic, shift and logic execute unit
// Two stages, operand fetch at pop then compute with registered writeback
module execUnit (
   input  logic nclk,
   input  logic nrst,
   input  logic headValid_i,
   input  logic [asluPkg::DataWidth-1:0] headData_i,
   input  logic [asluPkg::DataWidth-1:0] rdDataA_i,
   input  logic [asluPkg::DataWidth-1:0] rdDataB_i,
   output logic popReady_o,
   output logic [asluPkg::RegAddrWidth-1:0] rdAddrA_o,
   output logic [asluPkg::RegAddrWidth-1:0] rdAddrB_o,
   output logic wbEn_o,
   output logic [asluPkg::RegAddrWidth-1:0] wbAddr_o,
   output logic [asluPkg::DataWidth-1:0] wbData_o,
   output logic busy_o,
   output logic carry_o
);

   asluPkg::instrWord_u headWord;
   asluPkg::instrWord_u stageInstr;
   logic stageValid;
   logic [asluPkg::DataWidth-1:0] stageOpA;
   logic [asluPkg::DataWidth-1:0] stageOpB;
   logic pop;
   logic stageFwd;
   logic wbFwd;
   logic [asluPkg::DataWidth-1:0] fwdA;
   logic [asluPkg::DataWidth-1:0] fwdB;
   logic [asluPkg::OpcodeWidth-1:0] opcode;
   logic [asluPkg::OpcodeWidth-1:0] baseOp;
   logic [asluPkg::FuncWidth-1:0] func;
   logic [asluPkg::RegAddrWidth-1:0] stageRd;
   logic isImm;
   logic isSub;
   logic useCarry;
   logic keepCarry;
   logic isCmp;
   logic [asluPkg::DataWidth-1:0] immExt;
   logic [asluPkg::DataWidth-1:0] opA;
   logic [asluPkg::DataWidth-1:0] opB;
   logic addCarryIn;
   logic subCarryIn;
   logic addCarry;
   logic subCarry;
   logic [asluPkg::DataWidth-1:0] addSum;
   logic [asluPkg::DataWidth-1:0] subSum;
   logic cmpGreater;
   logic validOp;
   logic [asluPkg::DataWidth-1:0] aluResult;
   logic nextCarry;
   logic carryFlag;

   // Fetch side, pipeline never stalls
   assign headWord = headData_i;
   assign popReady_o = 1'b1;
   assign pop = headValid_i & popReady_o;
   assign rdAddrA_o = headWord.typeA.ra;
   assign rdAddrB_o = headWord.typeA.rb;

   // Bypass, newest producer first
   assign stageFwd = stageValid & validOp & (stageRd != '0);
   assign wbFwd = wbEn_o & (wbAddr_o != '0);
   assign fwdA = (stageFwd && stageRd == rdAddrA_o) ? aluResult :
                 (wbFwd && wbAddr_o == rdAddrA_o) ? wbData_o : rdDataA_i;
   assign fwdB = (stageFwd && stageRd == rdAddrB_o) ? aluResult :
                 (wbFwd && wbAddr_o == rdAddrB_o) ? wbData_o : rdDataB_i;

   // Decode of the staged word
   assign opcode = stageInstr.typeA.opcode;
   assign func = stageInstr.typeA.func;
   assign stageRd = stageInstr.typeA.rd;
   assign isImm = opcode[asluPkg::ImmSelBit];
   assign isSub = opcode[0];
   assign useCarry = opcode[1];
   assign keepCarry = opcode[2];
   assign isCmp = ~isImm & (baseOp == asluPkg::OpCmp) & func[0];
   assign immExt = {{(asluPkg::DataWidth-asluPkg::ImmWidth){stageInstr.typeB.imm[asluPkg::ImmWidth-1]}},
                    stageInstr.typeB.imm};

   always_comb begin
      baseOp = opcode;
      baseOp[asluPkg::ImmSelBit] = 1'b0;         // Fold immediate forms
   end

   assign opA = stageOpA;
   assign opB = isImm ? immExt : stageOpB;

   // Adder and reverse subtractor, carry out is not-borrow
   assign addCarryIn = useCarry & carryFlag;
   assign subCarryIn = ~useCarry | carryFlag;
   assign {addCarry, addSum} = ({1'b0, opB} + {1'b0, opA})
                              + {{asluPkg::DataWidth{1'b0}}, addCarryIn};
   assign {subCarry, subSum} = ({1'b0, opB} + {1'b0, ~opA})
                              + {{asluPkg::DataWidth{1'b0}}, subCarryIn};
   assign cmpGreater = func[1] ? (opA > opB) : ($signed(opA) > $signed(opB));

   // Result and carry select
   always_comb begin
      aluResult = '0;
      nextCarry = carryFlag;
      validOp = 1'b0;
      case (baseOp)
         asluPkg::OpAdd, asluPkg::OpRsub, asluPkg::OpAddc, asluPkg::OpRsubc,
         asluPkg::OpAddk, asluPkg::OpCmp, asluPkg::OpAddkc, asluPkg::OpRsubkc: begin
            validOp = 1'b1;
            aluResult = isSub ? subSum : addSum;
            if (isCmp) begin
               aluResult = {cmpGreater, subSum[asluPkg::DataWidth-2:0]}; // MSB is A > B
            end
            if (!keepCarry) begin
               nextCarry = isSub ? subCarry : addCarry;
            end
         end
         asluPkg::OpOr: begin
            validOp = 1'b1;
            aluResult = opA | opB;
         end
         asluPkg::OpAnd: begin
            validOp = 1'b1;
            aluResult = opA & opB;
         end
         asluPkg::OpXor: begin
            validOp = 1'b1;
            aluResult = opA ^ opB;
         end
         asluPkg::OpAndn: begin
            validOp = 1'b1;
            aluResult = opA & ~opB;
         end
         asluPkg::OpShift: begin
            validOp = ~isImm;                      // No immediate shifts
            case (func)
               asluPkg::FnSra: begin
                  aluResult = {opA[asluPkg::DataWidth-1], opA[asluPkg::DataWidth-1:1]};
                  nextCarry = opA[0];
               end
               asluPkg::FnSrc: begin
                  aluResult = {carryFlag, opA[asluPkg::DataWidth-1:1]}; // Rotate through C
                  nextCarry = opA[0];
               end
               asluPkg::FnSrl: begin
                  aluResult = {1'b0, opA[asluPkg::DataWidth-1:1]};
                  nextCarry = opA[0];
               end
               asluPkg::FnSext8: aluResult = {{(asluPkg::DataWidth-8){opA[7]}}, opA[7:0]};
               asluPkg::FnSext16: aluResult = {{(asluPkg::DataWidth-16){opA[15]}}, opA[15:0]};
               default: validOp = 1'b0;
            endcase
         end
         default: validOp = 1'b0;                 // Unknown opcode, no writeback
      endcase
   end

   // Stage 1 control
   always_ff @(posedge nclk) begin
      if (!nrst) begin
         stageValid <= 1'b0;
      end else begin
         stageValid <= pop;
      end
   end

   // Stage 1 payload
   always_ff @(posedge nclk) begin
      if (pop) begin
         stageInstr <= headWord;
         stageOpA <= fwdA;
         stageOpB <= fwdB;
      end
   end

   // Stage 2 control and carry flag
   always_ff @(posedge nclk) begin
      if (!nrst) begin
         wbEn_o <= 1'b0;
         carryFlag <= 1'b0;
      end else begin
         wbEn_o <= stageValid & validOp;
         if (stageValid) begin
            carryFlag <= nextCarry;
         end
      end
   end

   // Writeback payload
   always_ff @(posedge nclk) begin
      wbAddr_o <= stageRd;
      wbData_o <= aluResult;
   end

   assign carry_o = carryFlag;
   assign busy_o = stageValid | wbEn_o;          // Work still in flight

endmodule

// ==== logic/execCore.sv ====
// Integer execute subsystem top level
// APB command port, instruction queue, register file and execute unit
module execCore (
   input  logic nclk,
   input  logic nrst,
   input  logic psel_i,
   input  logic penable_i,
   input  logic pwrite_i,
   input  logic [asluPkg::ApbAddrWidth-1:0] paddr_i,
   input  logic [asluPkg::DataWidth-1:0] pwdata_i,
   output logic [asluPkg::DataWidth-1:0] prdata_o,
   output logic pready_o,
   output logic pslverr_o
);

   logic pushValid;
   logic [asluPkg::DataWidth-1:0] pushData;
   logic [asluPkg::QueueCountWidth-1:0] queueCount;
   logic headValid;
   logic [asluPkg::DataWidth-1:0] headData;
   logic popReady;
   logic hostWrEn;
   logic [asluPkg::RegAddrWidth-1:0] hostWrAddr;
   logic [asluPkg::DataWidth-1:0] hostWrData;
   logic [asluPkg::RegAddrWidth-1:0] hostRdAddr;
   logic [asluPkg::DataWidth-1:0] hostRdData;
   logic [asluPkg::RegAddrWidth-1:0] rdAddrA;
   logic [asluPkg::RegAddrWidth-1:0] rdAddrB;
   logic [asluPkg::DataWidth-1:0] rdDataA;
   logic [asluPkg::DataWidth-1:0] rdDataB;
   logic wbEn;
   logic [asluPkg::RegAddrWidth-1:0] wbAddr;
   logic [asluPkg::DataWidth-1:0] wbData;
   logic busy;
   logic carry;
   logic wrEn;
   logic [asluPkg::RegAddrWidth-1:0] wrAddr;
   logic [asluPkg::DataWidth-1:0] wrData;

   // Register write port, host only writes while idle
   assign wrEn = wbEn | hostWrEn;
   assign wrAddr = wbEn ? wbAddr : hostWrAddr;
   assign wrData = wbEn ? wbData : hostWrData;

   apbCmdPort cmdPort (
      .nclk(nclk), .nrst(nrst),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
      .paddr_i(paddr_i), .pwdata_i(pwdata_i),
      .queueCount_i(queueCount), .busy_i(busy), .carry_i(carry),
      .hostRdData_i(hostRdData),
      .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
      .pushValid_o(pushValid), .pushData_o(pushData),
      .hostWrEn_o(hostWrEn), .hostWrAddr_o(hostWrAddr), .hostWrData_o(hostWrData),
      .hostRdAddr_o(hostRdAddr)
   );

   instrQueue queue (
      .nclk(nclk), .nrst(nrst),
      .pushValid_i(pushValid), .pushData_i(pushData), .popReady_i(popReady),
      .headValid_o(headValid), .headData_o(headData), .count_o(queueCount)
   );

   regFile regs (
      .nclk(nclk), .nrst(nrst),
      .wrEn_i(wrEn), .wrAddr_i(wrAddr), .wrData_i(wrData),
      .rdAddrA_i(rdAddrA), .rdAddrB_i(rdAddrB), .rdAddrHost_i(hostRdAddr),
      .rdDataA_o(rdDataA), .rdDataB_o(rdDataB), .rdDataHost_o(hostRdData)
   );

   execUnit exec (
      .nclk(nclk), .nrst(nrst),
      .headValid_i(headValid), .headData_i(headData),
      .rdDataA_i(rdDataA), .rdDataB_i(rdDataB),
      .popReady_o(popReady), .rdAddrA_o(rdAddrA), .rdAddrB_o(rdAddrB),
      .wbEn_o(wbEn), .wbAddr_o(wbAddr), .wbData_o(wbData),
      .busy_o(busy), .carry_o(carry)
   );

endmodule

// ==== include/apbHostTasks.svh ====
// APB host side helpers for the execute subsystem testbench
// Bus transfers with a pready timeout and the value check
`ifndef APB_HOST_TASKS_SVH
`define APB_HOST_TASKS_SVH

   // Reports the reason, then the verdict, then stops
   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic checkValue(input string testName, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         stopOnError($sformatf("FAILED %s expected %08h actual %08h",
                               testName, expected, actual));
      end
   endtask

   // Setup and access phases up to the negedge of the last access cycle
   task automatic runTransfer(input logic writeEn,
                              input logic [asluPkg::ApbAddrWidth-1:0] addr,
                              input logic [asluPkg::DataWidth-1:0] wdata,
                              output logic [asluPkg::DataWidth-1:0] rdata,
                              output logic slvErr);
      int waitCycles;
      waitCycles = 0;
      @(posedge nclk);                           // Also the previous access edge
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= writeEn;
      paddr <= addr;
      pwdata <= wdata;
      @(posedge nclk);
      penable <= 1'b1;
      @(negedge nclk);                           // Outputs settled mid cycle
      while (pready !== 1'b1) begin
         waitCycles++;
         if (waitCycles > ApbWaitLimit) begin
            stopOnError("APB slave did not raise pready in time");
         end
         @(negedge nclk);
      end
      rdata = prdata;
      slvErr = pslverr;
   endtask

   task automatic writeWord(input logic [asluPkg::ApbAddrWidth-1:0] addr,
                            input logic [asluPkg::DataWidth-1:0] data, output logic slvErr);
      logic [asluPkg::DataWidth-1:0] unused;
      runTransfer(1'b1, addr, data, unused, slvErr);
   endtask

   task automatic readWord(input logic [asluPkg::ApbAddrWidth-1:0] addr,
                           output logic [asluPkg::DataWidth-1:0] data);
      logic slvErr;
      runTransfer(1'b0, addr, '0, data, slvErr);
      checkValue("apb_read", 32'd0, {31'd0, slvErr}); // Reads are never refused
   endtask

   task automatic releaseBus();
      @(posedge nclk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

`endif

// ==== verification/execCoreTb.sv ====
// Testbench for the integer execute subsystem
// Replays a command file over APB, checks registers, carry and error responses
module execCoreTb;

   localparam int ClkHalfPeriod = 4;
   localparam int ResetCycles = 5;
   localparam int ApbWaitLimit = 16;             // Cycles allowed for pready
   localparam int PollLimit = 64;                // Status reads per wait loop
   localparam int StatusEmptyBit = 3;
   localparam int StatusCarryBit = 4;
   localparam int StatusBusyBit = 5;             // Queued or in flight

   logic nclk;
   logic nrst;
   logic psel;
   logic penable;
   logic pwrite;
   logic [asluPkg::ApbAddrWidth-1:0] paddr;
   logic [asluPkg::DataWidth-1:0] pwdata;
   logic [asluPkg::DataWidth-1:0] prdata;
   logic pready;
   logic pslverr;

   `include "apbHostTasks.svh"

   execCore execCore_i (
      .nclk(nclk), .nrst(nrst),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata),
      .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
   );

   always #ClkHalfPeriod nclk = ~nclk;           // Period of 8

   // Register n lives at base + 4n
   function automatic logic [asluPkg::ApbAddrWidth-1:0] regAddress(input logic [31:0] regIndex);
      return asluPkg::AddrRegBase + {1'b0, regIndex[4:0], 2'b00};
   endfunction

   task automatic pollUntilRoom();
      logic [asluPkg::DataWidth-1:0] status;
      int polls;
      polls = 0;
      readWord(asluPkg::AddrStatus, status);
      while (status[2:0] == asluPkg::QueueFullCount) begin
         polls++;
         if (polls > PollLimit) begin
            stopOnError("Instruction queue stayed full for too long");
         end
         readWord(asluPkg::AddrStatus, status);
      end
   endtask

   // Empty queue and nothing in the pipeline
   task automatic drainCore();
      logic [asluPkg::DataWidth-1:0] status;
      int polls;
      polls = 0;
      readWord(asluPkg::AddrStatus, status);
      while (!status[StatusEmptyBit] || status[StatusBusyBit]) begin
         polls++;
         if (polls > PollLimit) begin
            stopOnError("Core did not finish its instructions in time");
         end
         readWord(asluPkg::AddrStatus, status);
      end
   endtask

   task automatic runCommand(input string testName, input string cmd,
                             input logic [31:0] fieldA, input logic [31:0] fieldB);
      logic [asluPkg::DataWidth-1:0] rdata;
      logic slvErr;
      if (cmd == "W") begin
         writeWord(regAddress(fieldA), fieldB, slvErr);
         checkValue(testName, 32'd0, {31'd0, slvErr});
      end else if (cmd == "I") begin
         pollUntilRoom();
         writeWord(asluPkg::AddrInstr, fieldA, slvErr);
         checkValue(testName, 32'd0, {31'd0, slvErr});
      end else if (cmd == "P") begin               // Back to back, no status poll
         writeWord(asluPkg::AddrInstr, fieldA, slvErr);
         checkValue(testName, 32'd0, {31'd0, slvErr});
      end else if (cmd == "D") begin
         drainCore();
      end else if (cmd == "R") begin
         readWord(regAddress(fieldA), rdata);
         checkValue(testName, fieldB, rdata);
      end else if (cmd == "C") begin
         readWord(asluPkg::AddrStatus, rdata);
         checkValue(testName, fieldA, {31'd0, rdata[StatusCarryBit]});
      end else if (cmd == "E") begin
         writeWord(regAddress(fieldA), fieldB, slvErr);
         checkValue(testName, 32'd1, {31'd0, slvErr}); // Must be refused
      end else begin
         stopOnError($sformatf("Unknown command %s in test %s", cmd, testName));
      end
   endtask

   initial begin
      int fd;
      int lineLen;
      int fields;
      string line;
      string testName;
      string cmd;
      logic [31:0] fieldA;
      logic [31:0] fieldB;
      nclk = 1'b0;
      nrst <= 1'b0;
      psel <= 1'b0;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= '0;
      pwdata <= '0;
      repeat (ResetCycles) @(posedge nclk);
      nrst <= 1'b1;
      fd = $fopen("verification/exec_tests.txt", "r");
      if (fd == 0) begin
         stopOnError("Could not open verification/exec_tests.txt");
      end
      while (!$feof(fd)) begin
         lineLen = $fgets(line, fd);
         if (lineLen == 0) begin
            break;
         end
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;                             // Blank or comment
         end
         fields = $sscanf(line, "%s %s %h %h", testName, cmd, fieldA, fieldB);
         if (fields != 4) begin
            stopOnError($sformatf("Malformed line in test file: %s", line));
         end
         runCommand(testName, cmd, fieldA, fieldB);
      end
      $fclose(fd);
      releaseBus();
      $display("All checks passed");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+include
logic/asluPkg.sv
logic/apbCmdPort.sv
logic/instrQueue.sv
logic/regFile.sv
logic/execUnit.sv
logic/execCore.sv
verification/execCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the execute subsystem testbench
VERILATOR ?= verilator
TOP ?= execCoreTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0
PASS_TEXT ?= All checks passed

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/apbHostTasks.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log is searched for the pass line, the exit status of the pipe is not used
run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/exec_tests.txt ====
# Columns: test name, command, field A, field B, hex fields, 0 where unused
# W reg value, I or P instr word, D drain, R reg expected, C carry, E reg value refused
rst_r5 R 05 00000000
rst_idle D 0 0
rst_carry C 0 0
ld_r0 W 00 12345678
ld_r1 W 01 0000000A
ld_r2 W 02 FFFFFFFF
ld_r3 W 03 80000000
ld_r4 W 04 00000005
ld_r15 W 0F F0F0F0F0
ld_r16 W 10 0FF00FF0
rd_r0 R 00 00000000
rd_r1 R 01 0000000A
rd_r15 R 0F F0F0F0F0
add_ovf I 00A11000 0
add_ovf D 0 0
add_ovf R 05 00000009
add_ovf C 1 0
addc_in I 08C12000 0
rsub_pos I 04E40800 0
rsubc_brw I 0D012000 0
arith_a D 0 0
addc_in R 06 00000010
rsub_pos R 07 00000005
rsubc_brw R 08 FFFFFFFB
rsubc_brw C 0 0
rsubc_nc I 0D240800 0
addk_keep I 11412000 0
addkc_keep I 19612000 0
cmp_signed I 15A32001 0
cmp_unsigned I 15C32003 0
arith_b D 0 0
rsubc_nc R 09 00000004
addk_keep R 0A 0000000F
addkc_keep R 0B 00000010
cmp_signed R 0D 00000005
cmp_unsigned R 0E 80000005
cmp_keep C 1 0
or_reg I 822F8000 0
and_reg I 864F8000 0
xor_reg I 8A6F8000 0
andn_reg I 8E8F8000 0
ori_imm I A2AF000F 0
andi_neg I A6CFFF00 0
xori_neg I AAEF8001 0
andni_imm I AF0F00F0 0
logic_all D 0 0
or_reg R 11 FFF0FFF0
and_reg R 12 00F000F0
xor_reg R 13 FF00FF00
andn_reg R 14 F000F000
ori_imm R 15 F0F0F0FF
andi_neg R 16 F0F0F000
xori_neg R 17 0F0F70F1
andni_imm R 18 F0F0F000
sra_neg I 93430001 0
srl_neg I 93A30041 0
shift_a D 0 0
sra_neg R 1A C0000000
srl_neg R 1D 40000000
srl_neg C 0 0
src_c0 I 93640021 0
src_c1 I 93840021 0
sext8 I 93D70060 0
sext16 I 93EF0061 0
shift_b D 0 0
src_c0 R 1B 00000002
src_c1 R 1C 80000002
sext8 R 1E FFFFFFF1
sext16 R 1F FFFFF0F0
sext_keep C 1 0
chain_1 P 00A12000 0
chain_2 P 00A52800 0
chain_3 P 04C42800 0
chain_4 P 88E62800 0
busy_wr E 14 DEADBEEF
chain D 0 0
chain_2 R 05 0000001E
chain_3 R 06 00000019
chain_4 R 07 00000007
busy_wr R 14 F000F000
chain C 1 0
